//--- design/rtcMapPkg.sv
package rtcMapPkg;

	//////////////////////////////
	// RTC register addresses
	typedef logic [7:0] rtcAddr; // Multiplexed bus address

	// Time block, seconds up to hours
	localparam rtcAddr timeFirst = 8'h21;
	localparam rtcAddr timeLast  = 8'h26;

	// Date block, day up to year
	localparam rtcAddr dateFirst = 8'h41;
	localparam rtcAddr dateLast  = 8'h43;

	localparam rtcAddr timerAddr = 8'h00; // Timer status, visited on pending irq
	localparam rtcAddr cmdAddr   = 8'hF0; // Command transfer, closes a scan

	// Edit cursor rest position
	localparam rtcAddr cursorHome = 8'h21;

	//////////////////////////////
	// Bus timing
	localparam int initCycles = 16; // Power-up delay before the first access
	localparam int busCycles  = 4;  // Latch, two strobes, done

	// Counter widths for the bus port
	localparam int initCntWidth = $clog2(initCycles);
	localparam int phaseWidth   = $clog2(busCycles + 1);

endpackage

//--- design/menuPkg.sv
package menuPkg;

	//////////////////////////////
	// Front panel
	typedef struct packed
	{
		logic left;   // Cursor up
		logic right;  // Cursor down
		logic centre; // Home cursor, ask for a write scan
	} buttons;

	//////////////////////////////
	// Sequencer to bus port
	typedef struct packed
	{
		logic valid;              // One-cycle strobe
		logic write;              // 1 write, 0 read
		rtcMapPkg::rtcAddr addr;  // Target register
	} busReq;

	//////////////////////////////
	// RTC bus pins
	typedef struct packed
	{
		logic cs;                // Chip select
		logic ale;               // Address latch enable
		logic rd;                // Read strobe
		logic wr;                // Write strobe
		rtcMapPkg::rtcAddr ad;   // Address/data lines, address phase only
	} rtcPins;

	//////////////////////////////
	// Scan timing
	localparam int scanGap = 3; // Idle cycles between two scans

	// Gap counter, counts 0 to scanGap-1
	localparam int gapCntWidth = $clog2(scanGap);

endpackage

//--- design/rtcBusPort.sv
`timescale 1ns/1ns

module rtcBusPort
(
	input  logic CLK,
	input  logic RST,
	input  menuPkg::busReq req,
	output logic ready,
	output logic done,
	output menuPkg::rtcPins rtc
);

	logic [rtcMapPkg::initCntWidth-1:0] initCnt;
	logic initDone; // Power-up finished, accesses allowed
	logic [rtcMapPkg::phaseWidth-1:0] phase; // 0 idle, 1 latch, then strobes, last done
	rtcMapPkg::rtcAddr heldAddr;
	logic heldWrite;
	logic strobe;

	//////////////////////////////
	// Power-up delay, one ready pulse
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			initCnt  <= '0;
			initDone <= 1'b0;
			ready    <= 1'b0;
		end
		else
		begin
			ready <= 1'b0; // Pulse only
			if (!initDone)
			begin
				initCnt <= initCnt + 1'b1;
				if (initCnt == rtcMapPkg::initCntWidth'(rtcMapPkg::initCycles - 1))
				begin
					initDone <= 1'b1;
					ready    <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// Access phase counter
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			phase <= '0;
		else if (phase == '0)
		begin
			if (req.valid && initDone)
				phase <= 1'b1; // Address cycle next
		end
		else if (phase == rtcMapPkg::phaseWidth'(rtcMapPkg::busCycles))
			phase <= '0; // Done cycle ends the access
		else
			phase <= phase + 1'b1;
	end

	// Address and direction kept for the whole access
	always_ff @(posedge CLK)
	begin
		if (phase == '0 && req.valid)
		begin
			heldAddr  <= req.addr;
			heldWrite <= req.write;
		end
	end

	assign done   = (phase == rtcMapPkg::phaseWidth'(rtcMapPkg::busCycles));
	assign strobe = (phase > rtcMapPkg::phaseWidth'(1)) && !done;

	// Pin decode
	always_comb
	begin
		rtc     = '0;
		rtc.cs  = (phase != '0) && !done;
		rtc.ale = (phase == rtcMapPkg::phaseWidth'(1));
		rtc.rd  = strobe && !heldWrite;
		rtc.wr  = strobe && heldWrite;
		if (rtc.ale)
			rtc.ad = heldAddr; // Address shown on latch cycle only
	end

endmodule

//--- design/scanSequencer.sv
`timescale 1ns/1ns

module scanSequencer
(
	input  logic CLK,
	input  logic RST,
	input  logic scanStart,
	input  logic writeMode,
	input  logic timerPending,
	input  logic done,
	output menuPkg::busReq req,
	output logic scanDone
);

	rtcMapPkg::rtcAddr curAddr;  // Address of the access in flight
	rtcMapPkg::rtcAddr nextAddr; // Following address in scan order
	logic busy;   // Scan running
	logic issue;  // Request strobe
	logic wrScan; // Direction of the whole scan
	logic lastAddr;

	//////////////////////////////
	// Scan order
	always_comb
	begin
		case (curAddr)
			rtcMapPkg::timeLast:
				nextAddr = rtcMapPkg::dateFirst; // Time block done, go to date
			rtcMapPkg::dateLast:
			begin
				// Timer status only while an interrupt is pending
				if (timerPending)
					nextAddr = rtcMapPkg::timerAddr;
				else
					nextAddr = rtcMapPkg::cmdAddr;
			end
			rtcMapPkg::timerAddr:
				nextAddr = rtcMapPkg::cmdAddr;
			default:
				nextAddr = curAddr + 8'd1; // Step inside a block
		endcase
	end

	assign lastAddr = (curAddr == rtcMapPkg::cmdAddr);

	//////////////////////////////
	// Address state and request strobe
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			busy    <= 1'b0;
			issue   <= 1'b0;
			wrScan  <= 1'b0;
			curAddr <= rtcMapPkg::timeFirst;
		end
		else
		begin
			issue <= 1'b0; // One-cycle request
			if (scanStart)
			begin
				busy    <= 1'b1;
				issue   <= 1'b1;
				curAddr <= rtcMapPkg::timeFirst; // Every scan opens on the time block
				wrScan  <= writeMode;            // Direction fixed for the scan
			end
			else if (busy && done)
			begin
				if (lastAddr)
					busy <= 1'b0; // Command address finished
				else
				begin
					issue   <= 1'b1;
					curAddr <= nextAddr;
				end
			end
		end
	end

	// Request to the bus port
	always_comb
	begin
		req.valid = issue;
		req.write = wrScan;
		req.addr  = curAddr;
	end

	// End of scan, same cycle as the last done
	assign scanDone = busy && done && lastAddr;

endmodule

//--- design/editCursor.sv
`timescale 1ns/1ns

module editCursor
(
	input  logic CLK,
	input  logic RST,
	input  menuPkg::buttons panel,
	output rtcMapPkg::rtcAddr cursor,
	output logic centrePress
);

	menuPkg::buttons prevBtn; // Levels one cycle back
	menuPkg::buttons edgeReg; // Registered rising edges
	rtcMapPkg::rtcAddr nextCursor;

	//////////////////////////////
	// Edge detect
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			prevBtn <= '0;
			edgeReg <= '0;
		end
		else
		begin
			prevBtn <= panel;
			edgeReg <= panel & ~prevBtn;
		end
	end

	assign centrePress = edgeReg.centre;

	//////////////////////////////
	// Cursor move with wrap
	always_comb
	begin
		nextCursor = cursor;
		if (edgeReg.centre)
			nextCursor = rtcMapPkg::cursorHome; // Centre wins
		else if (edgeReg.left && !edgeReg.right)
		begin
			case (cursor) // Up
				rtcMapPkg::timeLast: nextCursor = rtcMapPkg::dateFirst;
				rtcMapPkg::dateLast: nextCursor = rtcMapPkg::timeFirst;
				default:             nextCursor = cursor + 8'd1;
			endcase
		end
		else if (edgeReg.right && !edgeReg.left)
		begin
			case (cursor) // Down
				rtcMapPkg::timeFirst: nextCursor = rtcMapPkg::dateLast;
				rtcMapPkg::dateFirst: nextCursor = rtcMapPkg::timeLast;
				default:              nextCursor = cursor - 8'd1;
			endcase
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			cursor <= rtcMapPkg::cursorHome;
		else
			cursor <= nextCursor;
	end

endmodule

//--- design/menuControl.sv
`timescale 1ns/1ns

module menuControl
(
	input  logic CLK,
	input  logic RST,
	input  logic ready,
	input  logic scanDone,
	input  logic centrePress,
	input  logic rtcIrq,
	input  logic alarmBtn,
	output logic scanStart,
	output logic writeMode,
	output logic alarmStop
);

	typedef enum logic [1:0]
	{
		waitInit, // Bus port still powering up
		scanning, // Scan in progress
		gap       // Idle between scans
	} phaseT;

	phaseT phase;
	logic [menuPkg::gapCntWidth-1:0] gapCnt;
	logic centreFlag; // Centre press seen since last scan start

	//////////////////////////////
	// Phase machine
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			phase      <= waitInit;
			gapCnt     <= '0;
			scanStart  <= 1'b0;
			writeMode  <= 1'b1; // First scan loads the RTC
			centreFlag <= 1'b0;
		end
		else
		begin
			scanStart <= 1'b0;
			if (centrePress)
				centreFlag <= 1'b1; // Sticky until next start
			case (phase)
				waitInit:
				begin
					if (ready)
					begin
						scanStart  <= 1'b1;
						writeMode  <= 1'b1;
						centreFlag <= 1'b0;
						phase      <= scanning;
					end
				end
				scanning:
				begin
					if (scanDone)
					begin
						writeMode <= 1'b0;
						gapCnt    <= '0;
						phase     <= gap;
					end
				end
				gap:
				begin
					gapCnt <= gapCnt + 1'b1;
					if (gapCnt == menuPkg::gapCntWidth'(menuPkg::scanGap - 1))
					begin
						// Next scan writes only after a centre press
						scanStart  <= 1'b1;
						writeMode  <= centreFlag || centrePress;
						centreFlag <= 1'b0;
						phase      <= scanning;
					end
				end
				default:
					phase <= waitInit;
			endcase
		end
	end

	//////////////////////////////
	// Alarm stop
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			alarmStop <= 1'b0;
		else
			alarmStop <= rtcIrq && alarmBtn; // Irq and button both high
	end

endmodule

//--- design/rtcMenuTop.sv
`timescale 1ns/1ns

module rtcMenuTop
(
	input  logic CLK,
	input  logic RST,
	input  menuPkg::buttons panel,
	input  logic alarmBtn,
	input  logic rtcIrq,
	output menuPkg::rtcPins rtc,
	output rtcMapPkg::rtcAddr cursor,
	output logic writeMode,
	output logic alarmStop
);

	menuPkg::busReq req; // Sequencer to bus port
	logic ready;
	logic done;
	logic scanStart;
	logic scanDone;
	logic centrePress;

	// RTC bus timing
	rtcBusPort busPort0
	(
		.CLK   (CLK),
		.RST   (RST),
		.req   (req),
		.ready (ready),
		.done  (done),
		.rtc   (rtc)
	);

	// Register scan order
	scanSequencer seq0
	(
		.CLK          (CLK),
		.RST          (RST),
		.scanStart    (scanStart),
		.writeMode    (writeMode),
		.timerPending (rtcIrq), // Irq doubles as timer pending
		.done         (done),
		.req          (req),
		.scanDone     (scanDone)
	);

	editCursor cursor0
	(
		.CLK         (CLK),
		.RST         (RST),
		.panel       (panel),
		.cursor      (cursor),
		.centrePress (centrePress)
	);

	menuControl ctrl0
	(
		.CLK         (CLK),
		.RST         (RST),
		.ready       (ready),
		.scanDone    (scanDone),
		.centrePress (centrePress),
		.rtcIrq      (rtcIrq),
		.alarmBtn    (alarmBtn),
		.scanStart   (scanStart),
		.writeMode   (writeMode),
		.alarmStop   (alarmStop)
	);

endmodule

//--- dv/rtcMenuTb.sv
`timescale 1ns/1ns

module rtcMenuTb;

	localparam int clkPeriod    = 8;
	localparam int resetCycles  = 10;
	localparam int numScans     = 60;
	localparam int accessCycles = rtcMapPkg::busCycles + 1; // Request cycle plus bus access
	localparam int doneOffset   = rtcMapPkg::busCycles - 1; // Latch cycle to done cycle
	localparam int scanPause    = menuPkg::scanGap + 1;     // Extra cycles between two scans
	localparam int maxScanCycles = 11 * accessCycles + scanPause; // Time, date, timer, command
	localparam int firstAle     = rtcMapPkg::initCycles + 3; // Ready, start, request, then latch
	localparam int limitCycles  = resetCycles + firstAle + numScans * maxScanCycles + 200;

	logic CLK;
	logic RST;
	menuPkg::buttons panel;
	logic alarmBtn;
	logic rtcIrq;
	menuPkg::rtcPins rtc;
	rtcMapPkg::rtcAddr cursor;
	logic writeMode;
	logic alarmStop;

	//////////////////////////////
	// Stimulus state
	logic [31:0] lfsr;
	int holdCnt;              // Cycles left on the current button level
	logic [2:0] riseHist [4]; // Button rises with index 0 the last driven cycle

	//////////////////////////////
	// Reference model state
	int cyc;                   // Falling edges since reset release
	int aleCyc;                // Cycle of the next expected latch
	rtcMapPkg::rtcAddr expAddr;
	rtcMapPkg::rtcAddr expCursor;
	logic scanWrite;           // Direction of the running scan
	logic firstScan;
	logic pressFlag;           // Centre rise seen since the last scan start
	int wmCheckCyc;            // Cycle where writeMode must be low again
	int scanCount;
	int wrapCnt [4];           // 0x26 up, 0x43 up, 0x21 down, 0x41 down
	int readScans;
	int writeScans;
	int timerVisits;

	initial CLK = 1'b0;
	always #(clkPeriod / 2) CLK = ~CLK;

	rtcMenuTop dut0
	(
		.CLK       (CLK),
		.RST       (RST),
		.panel     (panel),
		.alarmBtn  (alarmBtn),
		.rtcIrq    (rtcIrq),
		.rtc       (rtc),
		.cursor    (cursor),
		.writeMode (writeMode),
		.alarmStop (alarmStop)
	);

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr); // One step per bit
			val  = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// Register order of one scan
	function automatic rtcMapPkg::rtcAddr nextScanAddr(input rtcMapPkg::rtcAddr cur,
		input logic irq);
		if (cur == rtcMapPkg::timeLast)
			return rtcMapPkg::dateFirst;
		else if (cur == rtcMapPkg::dateLast)
			return irq ? rtcMapPkg::timerAddr : rtcMapPkg::cmdAddr;
		else if (cur == rtcMapPkg::timerAddr)
			return rtcMapPkg::cmdAddr;
		return cur + 8'd1;
	endfunction

	task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s mismatch, got %0h expected %0h",
				$time, what, got, exp);
			$display("tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	//////////////////////////////
	// Cursor model on rise bits left right centre
	task automatic applyEdges(input logic [2:0] rise);
		if (rise[0])
			expCursor = rtcMapPkg::cursorHome; // Centre homes first
		else if (rise[2] && !rise[1])
		begin
			if (expCursor == rtcMapPkg::timeLast)
			begin
				expCursor = rtcMapPkg::dateFirst;
				wrapCnt[0]++;
			end
			else if (expCursor == rtcMapPkg::dateLast)
			begin
				expCursor = rtcMapPkg::timeFirst;
				wrapCnt[1]++;
			end
			else
				expCursor = expCursor + 8'd1;
		end
		else if (rise[1] && !rise[2])
		begin
			if (expCursor == rtcMapPkg::timeFirst)
			begin
				expCursor = rtcMapPkg::dateLast;
				wrapCnt[2]++;
			end
			else if (expCursor == rtcMapPkg::dateFirst)
			begin
				expCursor = rtcMapPkg::timeLast;
				wrapCnt[3]++;
			end
			else
				expCursor = expCursor - 8'd1;
		end
	endtask

	// Checks for one cycle on outputs settled since the rising edge
	task automatic checkCycle();
		menuPkg::rtcPins expPins;
		pressFlag = pressFlag | riseHist[3][0]; // Centre rise that reached the start edge
		applyEdges(riseHist[1]);                // Edge register plus cursor update
		compareValue(32'(cursor), 32'(expCursor), "cursor");
		compareValue(32'(alarmStop), 32'(rtcIrq & alarmBtn), "alarmStop");
		if (cyc == aleCyc && expAddr == rtcMapPkg::timeFirst)
		begin
			scanWrite = firstScan ? 1'b1 : pressFlag; // Load scan after reset
			pressFlag = 1'b0;
			firstScan = 1'b0;
			if (scanWrite)
				writeScans++;
			else
				readScans++;
		end
		if (cyc == aleCyc)
			compareValue(32'(writeMode), 32'(scanWrite), "writeMode in scan");
		if (cyc == wmCheckCyc)
			compareValue(32'(writeMode), 32'(0), "writeMode after scan");
		expPins = '0;
		if (cyc == aleCyc)
		begin
			expPins.cs  = 1'b1;
			expPins.ale = 1'b1;
			expPins.ad  = expAddr;
		end
		else if (cyc == aleCyc + 1 || cyc == aleCyc + 2)
		begin
			expPins.cs = 1'b1;
			expPins.rd = !scanWrite;
			expPins.wr = scanWrite;
		end
		compareValue(32'(rtc), 32'(expPins), "RTC bus pins");
	endtask

	//////////////////////////////
	// Buttons as random pulses and irq and alarm button as slow levels
	task automatic driveInputs();
		int v;
		menuPkg::buttons nextPanel;
		nextPanel = panel;
		if (holdCnt == 0)
		begin
			nextPanel = '0;
			if (panel != '0)
			begin
				drawBits(1, v);
				holdCnt = 1 + v; // Low for 2 to 3 cycles
			end
			else
			begin
				drawBits(4, v);
				if (v < 7)
					nextPanel.left = 1'b1;
				else if (v < 14)
					nextPanel.right = 1'b1;
				else if (v == 14)
				begin
					nextPanel.centre = 1'b1;
					drawBits(2, v);
					nextPanel.left  = v[1]; // Centre may come with a move it overrides
					nextPanel.right = v[0];
				end
				else
				begin
					nextPanel.left  = 1'b1; // Both cancel
					nextPanel.right = 1'b1;
				end
				drawBits(2, v);
				holdCnt = 1 + v; // High for 2 to 5 cycles
			end
		end
		else
			holdCnt--;
		for (int i = 3; i > 0; i--)
			riseHist[i] = riseHist[i - 1];
		riseHist[0] = nextPanel & ~panel;
		panel = nextPanel;
		drawBits(3, v);
		if (v == 0)
			rtcIrq = ~rtcIrq;
		drawBits(3, v);
		if (v == 0)
			alarmBtn = ~alarmBtn;
	endtask

	// On the done cycle the sequencer samples the irq just driven at the next edge
	task automatic advanceOrder();
		if (cyc == aleCyc + doneOffset)
		begin
			if (expAddr == rtcMapPkg::cmdAddr)
			begin
				aleCyc     = aleCyc + accessCycles + scanPause;
				expAddr    = rtcMapPkg::timeFirst;
				wmCheckCyc = cyc + 1;
				scanCount++;
			end
			else
			begin
				if (expAddr == rtcMapPkg::dateLast && rtcIrq)
					timerVisits++;
				expAddr = nextScanAddr(expAddr, rtcIrq);
				aleCyc  = aleCyc + accessCycles;
			end
		end
	endtask

	initial
	begin
		RST = 1'b1;
		panel = '0;
		alarmBtn = 1'b0;
		rtcIrq = 1'b0;
		lfsr = 32'hfde7_1f05;
		holdCnt = 0;
		foreach (riseHist[i])
			riseHist[i] = '0;
		foreach (wrapCnt[i])
			wrapCnt[i] = 0;
		cyc = 0;
		aleCyc = firstAle;
		expAddr = rtcMapPkg::timeFirst;
		expCursor = rtcMapPkg::cursorHome;
		scanWrite = 1'b1;
		firstScan = 1'b1;
		pressFlag = 1'b0;
		wmCheckCyc = -1;
		scanCount = 0;
		readScans = 0;
		writeScans = 0;
		timerVisits = 0;
		repeat (resetCycles) @(negedge CLK);
		RST = 1'b0; // Cycle 0 of the model
		while (scanCount < numScans)
		begin
			@(negedge CLK);
			cyc++;
			checkCycle();
			driveInputs();
			advanceOrder();
		end
		if (wrapCnt[0] == 0 || wrapCnt[1] == 0 || wrapCnt[2] == 0 || wrapCnt[3] == 0 ||
			readScans == 0 || writeScans == 0 || timerVisits == 0)
		begin
			$display("a wrap, read scan, write scan or timer visit never happened");
			$display("tests failed");
			$fatal(1, "stimulus did not reach every case");
		end
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

	//////////////////////////////
	// Watchdog
	initial
	begin
		#(limitCycles * clkPeriod);
		$display("watchdog expired before all scans finished");
		$display("tests failed");
		$fatal(1, "timeout");
	end

endmodule

//--- files.f
design/rtcMapPkg.sv
design/menuPkg.sv
design/rtcBusPort.sv
design/scanSequencer.sv
design/editCursor.sv
design/menuControl.sv
design/rtcMenuTop.sv
dv/rtcMenuTb.sv

//--- Makefile
# Verilator build and run of the RTC menu testbench

VERILATOR ?= verilator
TOP       ?= rtcMenuTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= all tests passed

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
